//--- vlog.f
hw/fcpu_pkg.sv
hw/fifo.sv
hw/reservation_station.sv
hw/memory_functional_unit.sv
hw/data_memory.sv
hw/cdb_arbiter.sv
hw/load_store_unit.sv
tests/load_store_unit_assert.sv
tests/tb_load_store_unit.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module tb_load_store_unit -o sim_tb

out=$(./obj_dir/sim_tb 2>&1) || true
echo "$out"

if grep -q 'All tests passed!' <<< "$out"; then
   exit 0
else
   exit 1
fi

//--- tests/tb_load_store_unit.sv
`default_nettype none

module tb_load_store_unit;

   import fcpu_pkg::*;

   localparam int TIMEOUT = 200;  // cycles per wait

   logic                      clk;
   logic                      nrst;
   logic                      i_valid;
   logic [ISSUE_W-1:0]        i_data;
   logic [N_MEM_OPERANDS-1:0] i_filled;
   logic                      o_ready;
   logic                      i_store_commit_valid;
   logic                      i_store_commit_invalidate;
   logic [RSV_ID_W-1:0]       i_store_commit_id;
   logic [CDB_W-1:0]          i_cdb;
   logic                      i_cdb_valid;
   logic [CDB_W-1:0]          o_cdb;
   logic                      o_cdb_valid;
   logic                      i_cdb_ready;

   logic [DATA_W-1:0]   ref_mem [logic [MEM_ADDR_W-1:0]];  // reference memory
   logic [RSV_ID_W-1:0] next_id;
   logic                issue_taken;  // issue transfer at the last rising edge
   integer              seed;

   load_store_unit i_load_store_unit (.*);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   always_ff @(posedge clk) begin
      issue_taken <= i_valid && o_ready;
   end

   task automatic abort_run();
      $display("Test failures found");
      $fatal(1, "simulation stopped on error");
   endtask

   task automatic check_cdb(input string name, input logic [CDB_W-1:0] exp,
                            input logic [CDB_W-1:0] act);
      if (act !== exp) begin
         $display("** Error %s: expected %h, actual %h", name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_data(input string name, input logic [DATA_W-1:0] exp,
                             input logic [DATA_W-1:0] act);
      if (act !== exp) begin
         $display("** Error %s: expected %h, actual %h", name, exp, act);
         abort_run();
      end
   endtask

   function automatic logic [DATA_W-1:0] rand_word();
      logic [31:0] r;
      r = $random(seed);
      return r[DATA_W-1:0];
   endfunction

   function automatic logic [RSV_ID_W-1:0] new_id();
      next_id = next_id + 1'b1;
      return next_id;
   endfunction

   // B forms subtract the offset from the base
   function automatic logic [MEM_ADDR_W-1:0] word_index(input logic [INSTR_W-1:0] op,
                                                        input logic [DATA_W-1:0] base,
                                                        input logic [DATA_W-1:0] off);
      logic [DATA_W-1:0] a;
      a = (op == I_LOADB || op == I_STOREB) ? base - off : base + off;
      return a[MEM_ADDR_W-1:0];
   endfunction

   task automatic issue_op(input string name, input logic [RSV_ID_W-1:0] id,
                           input logic [INSTR_W-1:0] op, input logic [DATA_W-1:0] base,
                           input logic [DATA_W-1:0] off, input logic [DATA_W-1:0] data,
                           input logic [N_MEM_OPERANDS-1:0] filled,
                           input logic [RSV_ID_W-1:0] base_tag,
                           input logic [RSV_ID_W-1:0] data_tag);
      int n;
      @(negedge clk);
      i_valid  = 1'b1;
      i_data   = {id, op, data_tag, data, base_tag, base, {RSV_ID_W{1'b0}}, off};
      i_filled = filled;
      for (n = 0; n < TIMEOUT; n++) begin
         @(negedge clk);
         if (issue_taken) break;
      end
      if (n == TIMEOUT) begin
         $display("%s: timeout, o_ready never rose for the issued instruction", name);
         abort_run();
      end
      i_valid = 1'b0;
   endtask

   // starts on a falling edge, ends on the falling edge after the transfer
   task automatic wait_result(input string name, output logic [CDB_W-1:0] got);
      int n;
      n = 0;
      while (!(o_cdb_valid && i_cdb_ready) && n < TIMEOUT) begin
         @(negedge clk);
         n++;
      end
      if (!(o_cdb_valid && i_cdb_ready)) begin
         $display("%s: timeout, no result came out on the CDB", name);
         abort_run();
      end
      got = o_cdb;
      @(negedge clk);
   endtask

   task automatic commit_store(input logic [RSV_ID_W-1:0] id, input logic inval);
      @(negedge clk);
      i_store_commit_valid      = 1'b1;
      i_store_commit_invalidate = inval;
      i_store_commit_id         = id;
      @(negedge clk);
      i_store_commit_valid      = 1'b0;
      i_store_commit_invalidate = 1'b0;
   endtask

   task automatic broadcast(input logic [RSV_ID_W-1:0] tag, input logic [DATA_W-1:0] value);
      @(negedge clk);
      i_cdb       = {tag, value};
      i_cdb_valid = 1'b1;
      @(negedge clk);
      i_cdb_valid = 1'b0;
   endtask

   task automatic store_word(input string name, input logic [INSTR_W-1:0] op,
                             input logic [DATA_W-1:0] base, input logic [DATA_W-1:0] off,
                             input logic [DATA_W-1:0] data);
      logic [RSV_ID_W-1:0] id;
      id = new_id();
      issue_op(name, id, op, base, off, data, 3'b111, '0, '0);
      commit_store(id, 1'b0);
      ref_mem[word_index(op, base, off)] = data;
   endtask

   task automatic load_word(input string name, input logic [INSTR_W-1:0] op,
                            input logic [DATA_W-1:0] base, input logic [DATA_W-1:0] off,
                            output logic [RSV_ID_W-1:0] id, output logic [CDB_W-1:0] got);
      id = new_id();
      issue_op(name, id, op, base, off, '0, 3'b111, '0, '0);
      wait_result(name, got);
   endtask

   task automatic load_check(input string name, input logic [INSTR_W-1:0] op,
                             input logic [DATA_W-1:0] base, input logic [DATA_W-1:0] off,
                             output logic [CDB_W-1:0] got);
      logic [RSV_ID_W-1:0] id;
      load_word(name, op, base, off, id, got);
      check_cdb(name, {id, ref_mem[word_index(op, base, off)]}, got);
   endtask

   task automatic test_store_load();
      logic [DATA_W-1:0] base;
      logic [DATA_W-1:0] off;
      logic [CDB_W-1:0]  got;
      base = rand_word();
      off  = rand_word();
      store_word("store_load", I_STORE, base, off, rand_word());
      load_check("store_load", I_LOAD, base, off, got);
   endtask

   task automatic test_forwarding();
      logic [RSV_ID_W-1:0] id;
      logic [RSV_ID_W-1:0] lid;
      logic [DATA_W-1:0]   base;
      logic [DATA_W-1:0]   off;
      logic [DATA_W-1:0]   data;
      logic [CDB_W-1:0]    got;
      base = rand_word();
      off  = rand_word();
      data = rand_word();
      id   = new_id();
      issue_op("forwarding", id, I_STORE, base, off, data, 3'b111, '0, '0);
      lid = new_id();
      issue_op("forwarding", lid, I_LOAD, base, off, '0, 3'b111, '0, '0);
      wait_result("forwarding", got);  // store still uncommitted
      check_cdb("forwarding", {lid, data}, got);
      commit_store(id, 1'b0);
      ref_mem[word_index(I_STORE, base, off)] = data;
      load_check("forwarding after commit", I_LOAD, base, off, got);
   endtask

   task automatic test_cdb_wakeup();
      logic [RSV_ID_W-1:0] id;
      logic [DATA_W-1:0]   base;
      logic [DATA_W-1:0]   off;
      logic [DATA_W-1:0]   data;
      logic [CDB_W-1:0]    got;
      base = rand_word();
      off  = rand_word();
      data = rand_word();
      id   = new_id();
      // only the offset is known at issue
      issue_op("cdb_wakeup", id, I_STORE, '0, off, '0, 3'b001, 4'hd, 4'he);
      broadcast(4'hd, base);
      broadcast(4'he, data);
      commit_store(id, 1'b0);
      ref_mem[word_index(I_STORE, base, off)] = data;
      load_check("cdb_wakeup", I_LOAD, base + off, '0, got);
   endtask

   task automatic test_invalidate();
      logic [RSV_ID_W-1:0] id;
      logic [RSV_ID_W-1:0] lid;
      logic [DATA_W-1:0]   base;
      logic [DATA_W-1:0]   off;
      logic [DATA_W-1:0]   old;
      logic [CDB_W-1:0]    got;
      base = rand_word();
      off  = rand_word();
      old  = rand_word();
      store_word("invalidate", I_STORE, base, off, old);
      id = new_id();
      issue_op("invalidate", id, I_STORE, base, off, ~old, 3'b111, '0, '0);
      commit_store(id, 1'b1);
      load_word("invalidate", I_LOAD, base, off, lid, got);
      check_data("invalidate", old, got[DATA_W-1:0]);
      check_cdb("invalidate", {lid, old}, got);
   endtask

   task automatic test_minus_addr();
      logic [RSV_ID_W-1:0] lid;
      logic [DATA_W-1:0]   diff;
      logic [DATA_W-1:0]   b1;
      logic [DATA_W-1:0]   b2;
      logic [DATA_W-1:0]   data;
      logic [CDB_W-1:0]    got;
      diff = rand_word();
      b1   = rand_word();
      b2   = rand_word();
      if (b2[6:0] == diff[6:0]) begin
         b2 = b2 ^ 16'h1;  // keeps b2+o2 off the diff word
      end
      store_word("minus_addr", I_STORE, b2, b2 - diff, rand_word());
      data = rand_word();
      store_word("minus_addr", I_STOREB, b1, b1 - diff, data);
      load_word("minus_loadb", I_LOADB, b2, b2 - diff, lid, got);
      check_data("minus_loadb", data, got[DATA_W-1:0]);
      check_cdb("minus_loadb", {lid, data}, got);
      load_check("minus_load", I_LOAD, b2, b2 - diff, got);
   endtask

   task automatic test_backpressure();
      logic [RSV_ID_W-1:0] ids [3];
      logic [DATA_W-1:0]   base;
      logic [CDB_W-1:0]    held;
      logic [CDB_W-1:0]    got;
      int                  n;
      base = rand_word();
      for (int k = 0; k < 3; k++) begin
         store_word("backpressure", I_STORE, base, DATA_W'(k), rand_word());
      end
      @(negedge clk);
      i_cdb_ready = 1'b0;
      for (int k = 0; k < 3; k++) begin
         ids[k] = new_id();
         issue_op("backpressure", ids[k], I_LOAD, base, DATA_W'(k), '0, 3'b111, '0, '0);
      end
      for (n = 0; n < TIMEOUT; n++) begin
         @(negedge clk);
         if (o_cdb_valid) break;
      end
      if (n == TIMEOUT) begin
         $display("backpressure: timeout, no result was offered on the CDB");
         abort_run();
      end
      held = o_cdb;
      repeat (8) begin
         @(negedge clk);
         if (!o_cdb_valid) begin
            $display("backpressure: o_cdb_valid dropped while i_cdb_ready was low");
            abort_run();
         end
         check_cdb("backpressure hold", held, o_cdb);
      end
      @(negedge clk);
      i_cdb_ready = 1'b1;
      for (int k = 0; k < 3; k++) begin
         wait_result("backpressure", got);
         check_cdb("backpressure", {ids[k], ref_mem[word_index(I_LOAD, base, DATA_W'(k))]}, got);
      end
   endtask

   initial begin
      seed                      = 32'he7ba2847;
      next_id                   = '0;
      nrst                      = 1'b1;
      i_valid                   = 1'b0;
      i_data                    = '0;
      i_filled                  = '0;
      i_store_commit_valid      = 1'b0;
      i_store_commit_invalidate = 1'b0;
      i_store_commit_id         = '0;
      i_cdb                     = '0;
      i_cdb_valid               = 1'b0;
      i_cdb_ready               = 1'b1;
      repeat (10) @(negedge clk);
      nrst = 1'b0;
      test_store_load();
      test_forwarding();
      test_cdb_wakeup();
      test_invalidate();
      test_minus_addr();
      test_backpressure();
      $display("All tests passed!");
      $finish;
   end

endmodule

`default_nettype wire

//--- tests/load_store_unit_assert.sv
`default_nettype none

module load_store_unit_assert (
   input wire                          clk,
   input wire                          nrst,
   input wire [fcpu_pkg::CDB_W-1:0]    i_out_cdb,
   input wire                          i_out_cdb_valid,
   input wire                          i_cdb_ready,
   input wire                          i_req_valid,
   input wire                          i_req_ready,
   input wire [fcpu_pkg::INSTR_W-1:0]  i_req_opcode,
   input wire [fcpu_pkg::RSV_ID_W-1:0] i_req_rsv_id,
   input wire [fcpu_pkg::DATA_W-1:0]   i_req_address,
   input wire [fcpu_pkg::DATA_W-1:0]   i_req_data
);

   // stalled result stays put
   a_cdb_hold: assert property (@(posedge clk) disable iff (nrst)
      i_out_cdb_valid && !i_cdb_ready |=> i_out_cdb_valid && $stable(i_out_cdb))
      else $error("outgoing CDB result changed while i_cdb_ready was low");

   a_reset_quiet: assert property (@(posedge clk)
      nrst && $past(nrst) |-> !i_out_cdb_valid && !i_req_valid)
      else $error("valid output seen during reset");

   a_req_hold: assert property (@(posedge clk) disable iff (nrst)
      i_req_valid && !i_req_ready |=> i_req_valid &&
         $stable({i_req_opcode, i_req_rsv_id, i_req_address, i_req_data}))
      else $error("memory request changed while refused");

endmodule

bind load_store_unit load_store_unit_assert u_lsu_assert (
   .clk            (clk),
   .nrst           (nrst),
   .i_out_cdb      (o_cdb),
   .i_out_cdb_valid(o_cdb_valid),
   .i_cdb_ready    (i_cdb_ready),
   .i_req_valid    (req_valid),
   .i_req_ready    (req_ready),
   .i_req_opcode   (req_opcode),
   .i_req_rsv_id   (req_rsv_id),
   .i_req_address  (req_address),
   .i_req_data     (req_data)
);

`default_nettype wire

//--- hw/load_store_unit.sv
`default_nettype none

module load_store_unit (
   input  wire                                clk,
   input  wire                                nrst,
   input  wire                                i_valid,
   input  wire [fcpu_pkg::ISSUE_W-1:0]        i_data,
   input  wire [fcpu_pkg::N_MEM_OPERANDS-1:0] i_filled,
   output logic                               o_ready,
   input  wire                                i_store_commit_valid,
   input  wire                                i_store_commit_invalidate,
   input  wire [fcpu_pkg::RSV_ID_W-1:0]       i_store_commit_id,
   input  wire [fcpu_pkg::CDB_W-1:0]          i_cdb,
   input  wire                                i_cdb_valid,
   output logic [fcpu_pkg::CDB_W-1:0]         o_cdb,
   output logic                               o_cdb_valid,
   input  wire                                i_cdb_ready
);

   import fcpu_pkg::*;

   // memory request
   logic                req_valid;
   logic [INSTR_W-1:0]  req_opcode;
   logic [RSV_ID_W-1:0] req_rsv_id;
   logic [DATA_W-1:0]   req_address;
   logic [DATA_W-1:0]   req_data;
   logic                req_ready;
   // result sources
   logic [CDB_W-1:0]    fwd_cdb;
   logic                fwd_cdb_valid;
   logic                fwd_cdb_ready;
   logic [CDB_W-1:0]    mem_cdb;
   logic                mem_cdb_valid;
   logic                mem_cdb_ready;

   memory_functional_unit u_mfu (
      .clk                      (clk),
      .nrst                     (nrst),
      .i_valid                  (i_valid),
      .i_data                   (i_data),
      .i_filled                 (i_filled),
      .o_ready                  (o_ready),
      .i_store_commit_valid     (i_store_commit_valid),
      .i_store_commit_invalidate(i_store_commit_invalidate),
      .i_store_commit_id        (i_store_commit_id),
      .i_cdb                    (i_cdb),
      .i_cdb_valid              (i_cdb_valid),
      .o_fwd_cdb                (fwd_cdb),
      .o_fwd_cdb_valid          (fwd_cdb_valid),
      .i_fwd_cdb_ready          (fwd_cdb_ready),
      .o_valid                  (req_valid),
      .o_opcode                 (req_opcode),
      .o_rsv_id                 (req_rsv_id),
      .o_address                (req_address),
      .o_data                   (req_data),
      .i_ready                  (req_ready)
   );

   data_memory u_dmem (
      .clk        (clk),
      .nrst       (nrst),
      .i_valid    (req_valid),
      .i_opcode   (req_opcode),
      .i_rsv_id   (req_rsv_id),
      .i_address  (req_address),
      .i_data     (req_data),
      .o_ready    (req_ready),
      .o_cdb      (mem_cdb),
      .o_cdb_valid(mem_cdb_valid),
      .i_cdb_ready(mem_cdb_ready)
   );

   cdb_arbiter u_arb (
      .i_mem_cdb      (mem_cdb),
      .i_mem_cdb_valid(mem_cdb_valid),
      .o_mem_cdb_ready(mem_cdb_ready),
      .i_fwd_cdb      (fwd_cdb),
      .i_fwd_cdb_valid(fwd_cdb_valid),
      .o_fwd_cdb_ready(fwd_cdb_ready),
      .o_cdb          (o_cdb),
      .o_cdb_valid    (o_cdb_valid),
      .i_cdb_ready    (i_cdb_ready)
   );

endmodule

`default_nettype wire

//--- hw/cdb_arbiter.sv
`default_nettype none

module cdb_arbiter (
   input  wire [fcpu_pkg::CDB_W-1:0]  i_mem_cdb,
   input  wire                        i_mem_cdb_valid,
   output logic                       o_mem_cdb_ready,
   input  wire [fcpu_pkg::CDB_W-1:0]  i_fwd_cdb,
   input  wire                        i_fwd_cdb_valid,
   output logic                       o_fwd_cdb_ready,
   output logic [fcpu_pkg::CDB_W-1:0] o_cdb,
   output logic                       o_cdb_valid,
   input  wire                        i_cdb_ready
);

   // memory result wins, it cannot be withdrawn
   assign o_cdb           = i_mem_cdb_valid ? i_mem_cdb : i_fwd_cdb;
   assign o_cdb_valid     = i_mem_cdb_valid || i_fwd_cdb_valid;
   assign o_mem_cdb_ready = i_cdb_ready;
   assign o_fwd_cdb_ready = i_cdb_ready && !i_mem_cdb_valid;

endmodule

`default_nettype wire

//--- hw/data_memory.sv
`default_nettype none

module data_memory (
   input  wire                           clk,
   input  wire                           nrst,
   input  wire                           i_valid,
   input  wire [fcpu_pkg::INSTR_W-1:0]   i_opcode,
   input  wire [fcpu_pkg::RSV_ID_W-1:0]  i_rsv_id,
   input  wire [fcpu_pkg::DATA_W-1:0]    i_address,
   input  wire [fcpu_pkg::DATA_W-1:0]    i_data,
   output logic                          o_ready,
   output logic [fcpu_pkg::CDB_W-1:0]    o_cdb,
   output logic                          o_cdb_valid,
   input  wire                           i_cdb_ready
);

   import fcpu_pkg::*;

   logic [DATA_W-1:0]     ram [2**MEM_ADDR_W];
   logic [MEM_ADDR_W-1:0] index;
   logic                  accept;
   logic                  is_load;

   assign index   = i_address[MEM_ADDR_W-1:0];
   assign o_ready = !o_cdb_valid || i_cdb_ready;  // result slot free or leaving
   assign accept  = i_valid && o_ready;
   assign is_load = i_opcode == I_LOAD || i_opcode == I_LOADB;

   always_ff @(posedge clk) begin
      if (accept && (i_opcode == I_STORE || i_opcode == I_STOREB)) begin
         ram[index] <= i_data;
      end
      if (accept && is_load) begin
         o_cdb <= {i_rsv_id, ram[index]};
      end
   end

   always_ff @(posedge clk) begin
      if (nrst) begin
         o_cdb_valid <= 1'b0;
      end else if (accept && is_load) begin
         o_cdb_valid <= 1'b1;
      end else if (i_cdb_ready) begin
         o_cdb_valid <= 1'b0;
      end
   end

endmodule

`default_nettype wire

//--- hw/memory_functional_unit.sv
`default_nettype none

module memory_functional_unit (
   input  wire                                clk,
   input  wire                                nrst,
   input  wire                                i_valid,
   input  wire [fcpu_pkg::ISSUE_W-1:0]        i_data,
   input  wire [fcpu_pkg::N_MEM_OPERANDS-1:0] i_filled,
   output logic                               o_ready,
   input  wire                                i_store_commit_valid,
   input  wire                                i_store_commit_invalidate,
   input  wire [fcpu_pkg::RSV_ID_W-1:0]       i_store_commit_id,
   input  wire [fcpu_pkg::CDB_W-1:0]          i_cdb,
   input  wire                                i_cdb_valid,
   output logic [fcpu_pkg::CDB_W-1:0]         o_fwd_cdb,
   output logic                               o_fwd_cdb_valid,
   input  wire                                i_fwd_cdb_ready,
   output logic                               o_valid,
   output logic [fcpu_pkg::INSTR_W-1:0]       o_opcode,
   output logic [fcpu_pkg::RSV_ID_W-1:0]      o_rsv_id,
   output logic [fcpu_pkg::DATA_W-1:0]        o_address,
   output logic [fcpu_pkg::DATA_W-1:0]        o_data,
   input  wire                                i_ready
);

   import fcpu_pkg::*;

   logic                                  issue_store;
   logic                                  rs_ready;
   logic                                  sb_ok;
   logic                                  p_valid;
   logic                                  p_ready;
   logic [RSV_ID_W+INSTR_W+2*DATA_W-1:0]  p_data;
   logic [DATA_W-1:0]                     p_addr;
   logic [RSV_ID_W+INSTR_W+DATA_W-1:0]    a_data;
   logic                                  a_valid;
   logic                                  a_ready;
   logic [RSV_ID_W-1:0]                   a_id;
   logic [INSTR_W-1:0]                    a_op;
   logic [DATA_W-1:0]                     a_addr;
   logic                                  a_load;
   logic                                  a_store;

   logic [STORE_BUFFER_SIZE-1:0]          sb_valid;
   logic [STORE_BUFFER_SIZE-1:0]          sb_data_rdy;
   logic [STORE_BUFFER_SIZE-1:0]          sb_addr_rdy;
   logic [STORE_BUFFER_SIZE-1:0]          sb_committed;
   logic [STORE_BUFFER_SIZE-1:0]          sb_inval;
   logic [STORE_BUFFER_SIZE-1:0]          sb_override;
   logic [RSV_ID_W-1:0]                   sb_id       [STORE_BUFFER_SIZE];
   logic [RSV_ID_W-1:0]                   sb_data_tag [STORE_BUFFER_SIZE];
   logic [DATA_W-1:0]                     sb_data     [STORE_BUFFER_SIZE];
   logic [DATA_W-1:0]                     sb_addr     [STORE_BUFFER_SIZE];
   logic [$clog2(STORE_BUFFER_SIZE)-1:0]  sb_head;
   logic [$clog2(STORE_BUFFER_SIZE)-1:0]  sb_tail;
   logic [STORE_BUFFER_SIZE-1:0]          sb_match;
   logic                                  sb_push;
   logic                                  sb_pop;
   logic                                  sb_drop;

   logic                                  bypass;
   logic                                  fwd_hit;
   logic [DATA_W-1:0]                     fwd_data;
   logic                                  store_req;
   logic                                  store_stall;
   logic                                  load_req;

   function automatic logic is_store(input logic [INSTR_W-1:0] op);
      return op == I_STORE || op == I_STOREB;
   endfunction

   function automatic logic is_load(input logic [INSTR_W-1:0] op);
      return op == I_LOAD || op == I_LOADB;
   endfunction

   // a store needs a free buffer entry at issue
   assign issue_store = is_store(i_data[N_MEM_OPERANDS*CDB_W +: INSTR_W]);
   assign sb_ok       = !(issue_store && sb_valid[sb_tail]);
   assign o_ready     = rs_ready && sb_ok;
   assign sb_push     = i_valid && o_ready && issue_store;

   reservation_station #(
      .N_OPERANDS  (2),
      .N_STATIONS_W(2)
   ) u_rs (
      .clk        (clk),
      .nrst       (nrst),
      .i_data     ({i_data[N_MEM_OPERANDS*CDB_W +: RSV_ID_W+INSTR_W], i_data[0 +: 2*CDB_W]}),
      .i_filled   (i_filled[1:0]),
      .i_valid    (i_valid && sb_ok),
      .o_ready    (rs_ready),
      .o_data     (p_data),
      .o_valid    (p_valid),
      .i_ready    (p_ready),
      .i_cdb      (i_cdb),
      .i_cdb_valid(i_cdb_valid)
   );

   // B forms take base minus offset
   assign p_addr = (p_data[2*DATA_W +: INSTR_W] == I_LOADB ||
                    p_data[2*DATA_W +: INSTR_W] == I_STOREB) ?
                   p_data[DATA_W +: DATA_W] - p_data[0 +: DATA_W] :
                   p_data[DATA_W +: DATA_W] + p_data[0 +: DATA_W];

   fifo #(
      .FIFO_DEPTH_W(2),
      .DATA_W      (RSV_ID_W+INSTR_W+DATA_W)
   ) u_addr_fifo (
      .clk      (clk),
      .nrst     (nrst),
      .i_a_data ({p_data[2*DATA_W +: RSV_ID_W+INSTR_W], p_addr}),
      .i_a_valid(p_valid),
      .o_a_ready(p_ready),
      .o_b_data (a_data),
      .o_b_valid(a_valid),
      .i_b_ready(a_ready)
   );

   assign {a_id, a_op, a_addr} = a_data;
   assign a_load  = a_valid && is_load(a_op);
   assign a_store = a_valid && is_store(a_op);

   // only stores with a known address are older than the head load
   always_comb begin
      fwd_hit  = 1'b0;
      fwd_data = '0;
      for (int i = 0; i < STORE_BUFFER_SIZE; i++) begin
         sb_match[i] = sb_valid[i] && sb_addr_rdy[i] && sb_addr[i] == a_addr;
         if (sb_match[i] && sb_data_rdy[i] && !sb_override[i] && !sb_inval[i]) begin
            fwd_hit  = 1'b1;
            fwd_data = sb_data[i];
         end
      end
   end

   assign bypass          = a_load && !(|sb_match);
   assign o_fwd_cdb_valid = a_load && fwd_hit;
   assign o_fwd_cdb       = {a_id, fwd_data};

   // loads first, but a refused store request is held until taken
   assign store_req = store_stall ||
                      (sb_valid[sb_head] && sb_data_rdy[sb_head] && sb_addr_rdy[sb_head] &&
                       sb_committed[sb_head] && !sb_inval[sb_head] &&
                       !bypass && !o_fwd_cdb_valid);
   assign load_req  = bypass && !store_req;
   assign sb_drop   = sb_valid[sb_head] && sb_committed[sb_head] && sb_inval[sb_head];
   assign sb_pop    = (store_req && i_ready) || sb_drop;
   assign a_ready   = !a_load || (load_req && i_ready) || (o_fwd_cdb_valid && i_fwd_cdb_ready);

   always_comb begin
      o_valid = load_req || store_req;
      if (store_req) begin
         o_opcode  = I_STORE;  // memory sees one store kind
         o_rsv_id  = sb_id[sb_head];
         o_address = sb_addr[sb_head];
         o_data    = sb_data[sb_head];
      end else begin
         o_opcode  = a_op;
         o_rsv_id  = a_id;
         o_address = a_addr;
         o_data    = '0;
      end
   end

   always_ff @(posedge clk) begin
      if (nrst) begin
         sb_valid    <= '0;
         sb_head     <= '0;
         sb_tail     <= '0;
         store_stall <= 1'b0;
      end else begin
         store_stall <= store_req && !i_ready;
         for (int i = 0; i < STORE_BUFFER_SIZE; i++) begin
            if (sb_valid[i] && !sb_data_rdy[i] && i_cdb_valid &&
                sb_data_tag[i] == i_cdb[DATA_W +: RSV_ID_W]) begin
               sb_data[i]     <= i_cdb[DATA_W-1:0];
               sb_data_rdy[i] <= 1'b1;
            end
            if (a_store && sb_valid[i]) begin
               if (sb_id[i] == a_id) begin
                  sb_addr[i]     <= a_addr;
                  sb_addr_rdy[i] <= 1'b1;
               end else if (sb_addr_rdy[i] && sb_addr[i] == a_addr) begin
                  sb_override[i] <= 1'b1;  // younger store to same word
               end
            end
            if (sb_valid[i] && i_store_commit_valid && sb_id[i] == i_store_commit_id) begin
               sb_committed[i] <= 1'b1;
               sb_inval[i]     <= i_store_commit_invalidate;
            end
         end
         if (sb_push) begin
            sb_valid[sb_tail]    <= 1'b1;
            sb_id[sb_tail]       <= i_data[N_MEM_OPERANDS*CDB_W+INSTR_W +: RSV_ID_W];
            sb_data_tag[sb_tail] <= i_data[2*CDB_W+DATA_W +: RSV_ID_W];
            if (!i_filled[2] && i_cdb_valid &&
                i_cdb[DATA_W +: RSV_ID_W] == i_data[2*CDB_W+DATA_W +: RSV_ID_W]) begin
               sb_data[sb_tail]     <= i_cdb[DATA_W-1:0];
               sb_data_rdy[sb_tail] <= 1'b1;
            end else begin
               sb_data[sb_tail]     <= i_data[2*CDB_W +: DATA_W];
               sb_data_rdy[sb_tail] <= i_filled[2];
            end
            sb_addr_rdy[sb_tail]  <= 1'b0;
            sb_committed[sb_tail] <= 1'b0;
            sb_inval[sb_tail]     <= 1'b0;
            sb_override[sb_tail]  <= 1'b0;
            sb_tail               <= sb_tail + 1'b1;
         end
         if (sb_pop) begin
            sb_valid[sb_head] <= 1'b0;
            sb_head           <= sb_head + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

//--- hw/reservation_station.sv
`default_nettype none

module reservation_station #(
   parameter int N_OPERANDS   = 2,
   parameter int N_STATIONS_W = 2
) (
   input  wire clk,
   input  wire nrst,
   input  wire [fcpu_pkg::RSV_ID_W+fcpu_pkg::INSTR_W+N_OPERANDS*fcpu_pkg::CDB_W-1:0] i_data,
   input  wire [N_OPERANDS-1:0] i_filled,
   input  wire i_valid,
   output logic o_ready,
   output logic [fcpu_pkg::RSV_ID_W+fcpu_pkg::INSTR_W+N_OPERANDS*fcpu_pkg::DATA_W-1:0] o_data,
   output logic o_valid,
   input  wire i_ready,
   input  wire [fcpu_pkg::CDB_W-1:0] i_cdb,
   input  wire i_cdb_valid
);

   import fcpu_pkg::*;

   logic [2**N_STATIONS_W-1:0] valid;
   logic [RSV_ID_W-1:0]        ent_id [2**N_STATIONS_W];
   logic [INSTR_W-1:0]         opcode [2**N_STATIONS_W];
   logic [RSV_ID_W-1:0]        tag    [2**N_STATIONS_W][N_OPERANDS];
   logic [DATA_W-1:0]          value  [2**N_STATIONS_W][N_OPERANDS];
   logic [N_OPERANDS-1:0]      filled [2**N_STATIONS_W];
   logic [N_STATIONS_W-1:0]    head;
   logic [N_STATIONS_W-1:0]    tail;
   logic [RSV_ID_W-1:0]        cdb_id;
   logic [DATA_W-1:0]          cdb_val;
   logic                       push;
   logic                       pop;

   assign cdb_id  = i_cdb[DATA_W +: RSV_ID_W];
   assign cdb_val = i_cdb[DATA_W-1:0];

   assign o_ready = !valid[tail];
   assign push    = i_valid && o_ready;
   // oldest entry only, memory order is kept
   assign o_valid = valid[head] && (&filled[head]);
   assign pop     = o_valid && i_ready;

   always_comb begin
      o_data[N_OPERANDS*DATA_W +: RSV_ID_W+INSTR_W] = {ent_id[head], opcode[head]};
      for (int k = 0; k < N_OPERANDS; k++) begin
         o_data[k*DATA_W +: DATA_W] = value[head][k];  // tags dropped
      end
   end

   always_ff @(posedge clk) begin
      if (nrst) begin
         valid <= '0;
         head  <= '0;
         tail  <= '0;
      end else begin
         // wakeup of waiting operands
         for (int e = 0; e < 2**N_STATIONS_W; e++) begin
            for (int k = 0; k < N_OPERANDS; k++) begin
               if (valid[e] && !filled[e][k] && i_cdb_valid && cdb_id == tag[e][k]) begin
                  value[e][k]  <= cdb_val;
                  filled[e][k] <= 1'b1;
               end
            end
         end
         if (push) begin
            valid[tail]  <= 1'b1;
            ent_id[tail] <= i_data[N_OPERANDS*CDB_W+INSTR_W +: RSV_ID_W];
            opcode[tail] <= i_data[N_OPERANDS*CDB_W +: INSTR_W];
            for (int k = 0; k < N_OPERANDS; k++) begin
               tag[tail][k] <= i_data[k*CDB_W+DATA_W +: RSV_ID_W];
               // broadcast in the issue cycle is caught here
               if (!i_filled[k] && i_cdb_valid &&
                   cdb_id == i_data[k*CDB_W+DATA_W +: RSV_ID_W]) begin
                  value[tail][k]  <= cdb_val;
                  filled[tail][k] <= 1'b1;
               end else begin
                  value[tail][k]  <= i_data[k*CDB_W +: DATA_W];
                  filled[tail][k] <= i_filled[k];
               end
            end
            tail <= tail + 1'b1;
         end
         if (pop) begin
            valid[head] <= 1'b0;
            head        <= head + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

//--- hw/fifo.sv
`default_nettype none

module fifo #(
   parameter int FIFO_DEPTH_W = 2,
   parameter int DATA_W       = 8
) (
   input  wire              clk,
   input  wire              nrst,
   input  wire [DATA_W-1:0] i_a_data,
   input  wire              i_a_valid,
   output logic             o_a_ready,
   output logic [DATA_W-1:0] o_b_data,
   output logic             o_b_valid,
   input  wire              i_b_ready
);

   logic [DATA_W-1:0]       mem [2**FIFO_DEPTH_W];
   logic [FIFO_DEPTH_W-1:0] wr_ptr;
   logic [FIFO_DEPTH_W-1:0] rd_ptr;
   logic [FIFO_DEPTH_W:0]   count;
   logic                    push;
   logic                    pop;

   assign o_a_ready = !count[FIFO_DEPTH_W];  // top bit set only when full
   assign o_b_valid = |count;
   assign o_b_data  = mem[rd_ptr];
   assign push      = i_a_valid && o_a_ready;
   assign pop       = o_b_valid && i_b_ready;

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= i_a_data;
      end
   end

   always_ff @(posedge clk) begin
      if (nrst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         if (push && !pop) begin
            count <= count + 1'b1;
         end else if (pop && !push) begin
            count <= count - 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

//--- hw/fcpu_pkg.sv
`default_nettype none

package fcpu_pkg;

   localparam int DATA_W   = 16;  // data and address width
   localparam int RSV_ID_W = 4;   // reorder buffer id, used as tag
   localparam int INSTR_W  = 4;

   // cdb word is id above data
   localparam int CDB_W = RSV_ID_W + DATA_W;

   // issue word is {id, opcode, slot 2, slot 1, slot 0}, each slot {tag, value}
   // slot 0 holds the offset, slot 1 the base, slot 2 the store data
   localparam int N_MEM_OPERANDS = 3;
   localparam int ISSUE_W        = RSV_ID_W + INSTR_W + N_MEM_OPERANDS * CDB_W;

   localparam logic [INSTR_W-1:0] I_LOAD   = 4'h1;  // base + offset
   localparam logic [INSTR_W-1:0] I_LOADB  = 4'h2;  // base - offset
   localparam logic [INSTR_W-1:0] I_STORE  = 4'h3;
   localparam logic [INSTR_W-1:0] I_STOREB = 4'h4;

   localparam int STORE_BUFFER_SIZE = 4;

   // ram index is the low address bits
   localparam int MEM_ADDR_W = 8;

endpackage

`default_nettype wire
